// File: design/daq_macros.svh
`ifndef DAQ_MACROS_SVH
`define DAQ_MACROS_SVH

// Stream and buffer sizing
`define DAQ_DATA_W          16
`define DAQ_FIFO_DEPTH      16

// Fixed sequencer delays in Clk cycles
`define DAQ_T_POWER_RESET   16'd8   // LVDS receiver wake-up
`define DAQ_T_RESET_START   40      // Internal chip management after reset
`define DAQ_T_SRO           16'd16  // Start-readout pulse length

// AXI4-Lite register map
`define DAQ_ADDR_CTRL       4'h0
`define DAQ_ADDR_ACQ_TIME   4'h4
`define DAQ_ADDR_HOLD_TIME  4'h8
`define DAQ_ADDR_STATUS     4'hC

// Trailer codes
`define DAQ_TAIL_MARK       16'hFF45
`define DAQ_COUNT_TAG       8'hCC

`endif

// File: design/daqCtrlPkg.sv
package daqCtrlPkg;

    // Acquisition sequencer states, in cycle order
    typedef enum logic [3:0] {
        Idle         = 4'd0,
        ChipReset    = 4'd1,
        PowerOn      = 4'd2,
        Release      = 4'd3,
        WaitStart    = 4'd4,
        Acquire      = 4'd5,
        WaitRead     = 4'd6,
        StartRead    = 4'd7,
        WaitReadDone = 4'd8,
        OnceEnd      = 4'd9,
        OutTail      = 4'd10,
        OutCount1    = 4'd11,
        OutCount2    = 4'd12,
        AllDone      = 4'd13
    } daqState_t;

    typedef logic [15:0] cfgTime_t;  // Delay value in Clk cycles

endpackage

// File: design/daqDataPkg.sv
`include "daq_macros.svh"

package daqDataPkg;

    typedef logic [`DAQ_DATA_W-1:0] daqWord_t;  // One stream word
    typedef logic [23:0] trigCount_t;           // Triggers seen in one run

endpackage

// File: design/daqConfigRegs.sv
`timescale 1ns/1ps
`include "daq_macros.svh"

module daqConfigRegs (
    input  logic                 Clk,
    input  logic                 reset_n,
    input  logic                 awValid,
    output logic                 awReady,
    input  logic [3:0]           awAddr,
    input  logic                 wValid,
    output logic                 wReady,
    input  logic [31:0]          wData,
    input  logic [3:0]           wStrb,
    output logic                 bValid,
    input  logic                 bReady,
    output logic [1:0]           bResp,
    input  logic                 arValid,
    output logic                 arReady,
    input  logic [3:0]           arAddr,
    output logic                 rValid,
    input  logic                 rReady,
    output logic [31:0]          rData,
    output logic [1:0]           rResp,
    input  daqCtrlPkg::daqState_t state,
    input  logic                 overflow,
    input  logic                 allDone,
    output logic                 runEnable,
    output daqCtrlPkg::cfgTime_t  acqTime,
    output daqCtrlPkg::cfgTime_t  holdTime
);

    logic        awHeld;
    logic        wHeld;
    logic [3:0]  awAddrQ;
    logic [31:0] wDataQ;
    logic [3:0]  wStrbQ;
    logic        awFire;
    logic        wFire;
    logic        doWrite;
    logic [3:0]  wrAddr;
    logic [31:0] wrData;
    logic [3:0]  wrStrb;

    ////////////////////
    // Write channels

    assign awReady = !awHeld && !bValid;
    assign wReady  = !wHeld && !bValid;
    assign awFire  = awValid && awReady;
    assign wFire   = wValid && wReady;
    assign doWrite = (awHeld || awFire) && (wHeld || wFire);  // Both halves in

    assign wrAddr = awHeld ? awAddrQ : awAddr;
    assign wrData = wHeld ? wDataQ : wData;
    assign wrStrb = wHeld ? wStrbQ : wStrb;
    assign bResp  = 2'b00;  // Always OKAY
    assign rResp  = 2'b00;

    always_ff @(posedge Clk) begin
        if (awFire) awAddrQ <= awAddr;
        if (wFire) begin
            wDataQ <= wData;
            wStrbQ <= wStrb;
        end
    end

    always_ff @(posedge Clk or negedge reset_n) begin
        if (!reset_n) begin
            awHeld    <= 1'b0;
            wHeld     <= 1'b0;
            bValid    <= 1'b0;
            runEnable <= 1'b0;
            acqTime   <= 16'd8;
            holdTime  <= 16'd4;
        end else begin
            awHeld <= (awHeld || awFire) && !doWrite;
            wHeld  <= (wHeld || wFire) && !doWrite;
            if (doWrite) begin
                bValid <= 1'b1;  // Response one cycle after completion
                case (wrAddr)
                    `DAQ_ADDR_CTRL: if (wrStrb[0]) runEnable <= wrData[0];
                    `DAQ_ADDR_ACQ_TIME: begin
                        if (wrStrb[0]) acqTime[7:0] <= wrData[7:0];
                        if (wrStrb[1]) acqTime[15:8] <= wrData[15:8];
                    end
                    `DAQ_ADDR_HOLD_TIME: begin
                        if (wrStrb[0]) holdTime[7:0] <= wrData[7:0];
                        if (wrStrb[1]) holdTime[15:8] <= wrData[15:8];
                    end
                    default: ;  // Status is read-only
                endcase
            end else if (bReady) begin
                bValid <= 1'b0;
            end
        end
    end

    ////////////////////
    // Read channels

    assign arReady = !rValid;

    always_ff @(posedge Clk or negedge reset_n) begin
        if (!reset_n)
            rValid <= 1'b0;
        else if (arValid && arReady)
            rValid <= 1'b1;
        else if (rReady)
            rValid <= 1'b0;
    end

    always_ff @(posedge Clk) begin
        if (arValid && arReady) begin
            case (arAddr)
                `DAQ_ADDR_CTRL:      rData <= {31'd0, runEnable};
                `DAQ_ADDR_ACQ_TIME:  rData <= {16'd0, acqTime};
                `DAQ_ADDR_HOLD_TIME: rData <= {16'd0, holdTime};
                `DAQ_ADDR_STATUS:    rData <= {26'd0, allDone, overflow, state};
                default:             rData <= 32'd0;
            endcase
        end
    end

    // Host must see the response until it takes it
    assert property (@(posedge Clk) disable iff (!reset_n)
        bValid && !bReady |=> bValid);

endmodule

// File: design/slaveDaq.sv
`timescale 1ns/1ps
`include "daq_macros.svh"

module slaveDaq (
    input  logic                  Clk,
    input  logic                  reset_n,
    input  logic                  runEnable,
    input  daqCtrlPkg::cfgTime_t   acqTime,
    input  daqCtrlPkg::cfgTime_t   holdTime,
    input  logic                  asicTrigger,
    input  logic                  asicChipSatB,    // Chip full, active low
    input  logic                  asicEndReadout,
    input  daqDataPkg::daqWord_t   asicData,
    input  logic                  asicDataValid,
    input  logic                  transmitDone,
    output logic                  resetB,          // ASIC digital reset, active low
    output logic                  startAcq,
    output logic                  startReadout,
    output logic                  pwrOnA,
    output logic                  pwrOnD,
    output logic                  pwrOnDac,
    output logic                  onceEnd,
    output logic                  allDone,
    output daqCtrlPkg::daqState_t  state,
    output daqDataPkg::daqWord_t   wordOut,
    output logic                  wordValid
);

    import daqCtrlPkg::*;
    import daqDataPkg::*;

    logic [2:0] trigSync;
    logic [2:0] satSync;
    logic [2:0] endSync;
    logic       trigEdge;
    logic       chipFull;
    logic       satRise;
    logic       endRise;
    cfgTime_t   delayCnt;
    logic       trigEn;
    logic       readDone;
    trigCount_t trigCount;

    ////////////////////
    // Input synchronizers

    always_ff @(posedge Clk or negedge reset_n) begin
        if (!reset_n) begin
            trigSync <= 3'b000;
            satSync  <= 3'b111;  // Saturation rests high
            endSync  <= 3'b000;
        end else begin
            trigSync <= {trigSync[1:0], asicTrigger};
            satSync  <= {satSync[1:0], asicChipSatB};
            endSync  <= {endSync[1:0], asicEndReadout};
        end
    end

    assign trigEdge = trigSync[1] && !trigSync[2];
    assign chipFull = !satSync[1] && satSync[2];  // Falling edge, some chip is full
    assign satRise  = satSync[1] && !satSync[2];  // Readout may start
    assign endRise  = endSync[1] && !endSync[2];

    ////////////////////
    // Sequencer

    always_ff @(posedge Clk or negedge reset_n) begin
        if (!reset_n) begin
            state        <= Idle;
            delayCnt     <= '0;
            resetB       <= 1'b1;
            startAcq     <= 1'b0;
            startReadout <= 1'b0;
            onceEnd      <= 1'b0;
            allDone      <= 1'b0;
            trigEn       <= 1'b0;
            readDone     <= 1'b0;
        end else begin
            if (endRise) readDone <= 1'b1;  // End pulse may come during StartRead
            case (state)
                Idle: if (runEnable) begin
                    resetB <= 1'b0;
                    state  <= ChipReset;
                end
                ChipReset: state <= PowerOn;
                PowerOn: if (delayCnt < `DAQ_T_POWER_RESET) begin
                    delayCnt <= delayCnt + 1'b1;
                end else begin
                    delayCnt <= '0;
                    resetB   <= 1'b1;
                    state    <= Release;
                end
                Release: if (delayCnt < cfgTime_t'(`DAQ_T_RESET_START)) begin
                    delayCnt <= delayCnt + 1'b1;
                end else begin
                    delayCnt <= '0;
                    trigEn   <= 1'b1;
                    state    <= WaitStart;
                end
                WaitStart: if (!runEnable) begin
                    trigEn <= 1'b0;
                    state  <= OutTail;
                end else if (trigEdge) begin
                    startAcq <= 1'b1;
                    state    <= Acquire;
                end
                Acquire: if (delayCnt >= acqTime || chipFull) begin
                    delayCnt <= '0;
                    startAcq <= 1'b0;
                    state    <= WaitRead;
                end else begin
                    delayCnt <= delayCnt + 1'b1;
                end
                WaitRead: begin
                    readDone <= 1'b0;
                    if (satRise) begin
                        startReadout <= 1'b1;
                        state        <= StartRead;
                    end
                end
                StartRead: if (delayCnt < `DAQ_T_SRO) begin
                    delayCnt <= delayCnt + 1'b1;
                end else begin
                    delayCnt     <= '0;
                    startReadout <= 1'b0;
                    state        <= WaitReadDone;
                end
                WaitReadDone: if (readDone || endRise) begin
                    onceEnd <= 1'b1;
                    state   <= OnceEnd;
                end
                OnceEnd: if (delayCnt < holdTime) begin
                    delayCnt <= delayCnt + 1'b1;
                end else begin
                    delayCnt <= '0;
                    onceEnd  <= 1'b0;
                    state    <= WaitStart;
                end
                OutTail, OutCount1, OutCount2: begin
                    // Each trailer word takes two cycles
                    delayCnt <= (delayCnt == '0) ? 16'd1 : 16'd0;
                    if (delayCnt != '0) begin
                        if (state == OutTail) state <= OutCount1;
                        else if (state == OutCount1) state <= OutCount2;
                        else begin
                            allDone <= 1'b1;
                            state   <= AllDone;
                        end
                    end
                end
                AllDone: if (transmitDone) begin
                    allDone <= 1'b0;
                    state   <= Idle;
                end
                default: state <= Idle;
            endcase
        end
    end

    // Trigger counter, cleared at run start
    always_ff @(posedge Clk or negedge reset_n) begin
        if (!reset_n)
            trigCount <= '0;
        else if (state == Idle && runEnable)
            trigCount <= '0;
        else if (trigEn && trigEdge)
            trigCount <= trigCount + 1'b1;  // Wraps at 24 bits
    end

    ////////////////////
    // Power and data outputs

    assign pwrOnA   = state >= ChipReset && state <= OnceEnd;
    assign pwrOnDac = pwrOnA;
    assign pwrOnD   = state >= PowerOn && state <= OnceEnd;

    always_comb begin
        case (state)
            OutTail: begin
                wordOut   = `DAQ_TAIL_MARK;
                wordValid = delayCnt == '0;
            end
            OutCount1: begin
                wordOut   = {`DAQ_COUNT_TAG, trigCount[23:16]};
                wordValid = delayCnt == '0;
            end
            OutCount2: begin
                wordOut   = trigCount[15:0];
                wordValid = delayCnt == '0;
            end
            default: begin
                wordOut   = asicData;
                wordValid = asicDataValid && (state == StartRead || state == WaitReadDone);
            end
        endcase
    end

    // Acquisition only opens from a trigger seen while waiting
    assert property (@(posedge Clk) disable iff (!reset_n)
        $rose(startAcq) |-> $past(state) == WaitStart);

    assert property (@(posedge Clk) disable iff (!reset_n)
        $rose(wordValid) |-> !(state inside {ChipReset, PowerOn, Release}));

endmodule

// File: design/dataFifo.sv
`timescale 1ns/1ps
`include "daq_macros.svh"

module dataFifo #(
    parameter int DEPTH = `DAQ_FIFO_DEPTH
) (
    input  logic                Clk,
    input  logic                reset_n,
    input  daqDataPkg::daqWord_t wrData,
    input  logic                wrEn,
    input  logic                rdEn,
    output daqDataPkg::daqWord_t rdData,
    output logic                empty,
    output logic                full,
    output logic                overflow  // Sticky until reset
);

    import daqDataPkg::*;

    localparam int PtrW = $clog2(DEPTH);

    daqWord_t        mem [DEPTH];
    logic [PtrW-1:0] wrPtr;
    logic [PtrW-1:0] rdPtr;
    logic [PtrW:0]   count;
    logic            doWr;
    logic            doRd;

    assign empty = count == '0;
    assign full  = count == (PtrW+1)'(DEPTH);
    assign doWr  = wrEn && !full;  // Writes into a full buffer are lost
    assign doRd  = rdEn && !empty;

    always_ff @(posedge Clk) begin
        if (doWr) mem[wrPtr] <= wrData;
        if (doRd) rdData <= mem[rdPtr];  // Held until the next read
    end

    always_ff @(posedge Clk or negedge reset_n) begin
        if (!reset_n) begin
            wrPtr    <= '0;
            rdPtr    <= '0;
            count    <= '0;
            overflow <= 1'b0;
        end else begin
            if (doWr) wrPtr <= (wrPtr == PtrW'(DEPTH - 1)) ? '0 : wrPtr + 1'b1;
            if (doRd) rdPtr <= (rdPtr == PtrW'(DEPTH - 1)) ? '0 : rdPtr + 1'b1;
            count <= count + (PtrW+1)'(doWr) - (PtrW+1)'(doRd);
            if (wrEn && full) overflow <= 1'b1;
        end
    end

    assert property (@(posedge Clk) disable iff (!reset_n) rdEn |-> !empty);

endmodule

// File: design/streamOut.sv
`timescale 1ns/1ps

module streamOut (
    input  logic                Clk,
    input  logic                reset_n,
    input  daqDataPkg::daqWord_t fifoData,
    input  logic                fifoEmpty,
    input  logic                allDone,
    input  logic                outReady,
    output logic                fifoRd,
    output daqDataPkg::daqWord_t outData,
    output logic                outValid,
    output logic                transmitDone
);

    logic doneSent;
    logic lastOut;

    // The FIFO read register is the output slot, this tracks whether it is full
    assign outData = fifoData;
    assign fifoRd  = !fifoEmpty && (!outValid || outReady);
    assign lastOut = allDone && fifoEmpty && !outValid && !doneSent;

    always_ff @(posedge Clk or negedge reset_n) begin
        if (!reset_n) begin
            outValid     <= 1'b0;
            transmitDone <= 1'b0;
            doneSent     <= 1'b0;
        end else begin
            if (fifoRd)
                outValid <= 1'b1;  // Refill on the same edge as the transfer
            else if (outReady)
                outValid <= 1'b0;
            transmitDone <= lastOut;                      // One pulse per run
            doneSent     <= allDone && (doneSent || lastOut);
        end
    end

    // Word must hold until the host takes it
    assert property (@(posedge Clk) disable iff (!reset_n)
        outValid && !outReady |=> outValid && $stable(outData));

endmodule

// File: design/daqTop.sv
`timescale 1ns/1ps
`include "daq_macros.svh"

module daqTop (
    input  logic                Clk,
    input  logic                reset_n,
    input  logic                awValid,
    output logic                awReady,
    input  logic [3:0]          awAddr,
    input  logic                wValid,
    output logic                wReady,
    input  logic [31:0]         wData,
    input  logic [3:0]          wStrb,
    output logic                bValid,
    input  logic                bReady,
    output logic [1:0]          bResp,
    input  logic                arValid,
    output logic                arReady,
    input  logic [3:0]          arAddr,
    output logic                rValid,
    input  logic                rReady,
    output logic [31:0]         rData,
    output logic [1:0]          rResp,
    input  logic                asicTrigger,
    input  logic                asicChipSatB,
    input  logic                asicEndReadout,
    input  daqDataPkg::daqWord_t asicData,
    input  logic                asicDataValid,
    output logic                resetB,
    output logic                startAcq,
    output logic                startReadout,
    output logic                pwrOnA,
    output logic                pwrOnD,
    output logic                pwrOnDac,
    output logic                onceEnd,
    output logic                allDone,
    output logic                transmitDone,
    output daqDataPkg::daqWord_t outData,
    output logic                outValid,
    input  logic                outReady
);

    import daqCtrlPkg::*;
    import daqDataPkg::*;

    logic      runEnable;
    cfgTime_t  acqTime;
    cfgTime_t  holdTime;
    daqState_t state;
    logic      overflow;
    daqWord_t  wordOut;
    logic      wordValid;
    daqWord_t  fifoData;
    logic      fifoEmpty;
    logic      fifoRd;

    daqConfigRegs regs0 (
        .Clk, .reset_n,
        .awValid, .awReady, .awAddr, .wValid, .wReady, .wData, .wStrb,
        .bValid, .bReady, .bResp, .arValid, .arReady, .arAddr,
        .rValid, .rReady, .rData, .rResp,
        .state, .overflow, .allDone,
        .runEnable, .acqTime, .holdTime
    );

    slaveDaq daq0 (
        .Clk, .reset_n, .runEnable, .acqTime, .holdTime,
        .asicTrigger, .asicChipSatB, .asicEndReadout, .asicData, .asicDataValid,
        .transmitDone, .resetB, .startAcq, .startReadout,
        .pwrOnA, .pwrOnD, .pwrOnDac, .onceEnd, .allDone, .state,
        .wordOut, .wordValid
    );

    dataFifo #(.DEPTH(`DAQ_FIFO_DEPTH)) fifo0 (
        .Clk, .reset_n,
        .wrData   (wordOut),
        .wrEn     (wordValid),
        .rdEn     (fifoRd),
        .rdData   (fifoData),
        .empty    (fifoEmpty),
        .full     (),
        .overflow
    );

    streamOut out0 (
        .Clk, .reset_n, .fifoData, .fifoEmpty, .allDone, .outReady,
        .fifoRd, .outData, .outValid, .transmitDone
    );

endmodule

// File: test/tb_daqTop.sv
`timescale 1ns/1ps
`include "daq_macros.svh"

module tb_daqTop;

    import daqCtrlPkg::*;
    import daqDataPkg::*;

    localparam int TimeoutCycles = 6000;  // Sum of all tests with margin

    logic        Clk = 1'b0;
    logic        reset_n;
    logic        awValid, wValid, bReady, arValid, rReady;
    logic        awReady, wReady, bValid, arReady, rValid;
    logic [3:0]  awAddr, arAddr, wStrb;
    logic [31:0] wData, rData;
    logic [1:0]  bResp, rResp;
    logic        asicTrigger, asicChipSatB, asicEndReadout, asicDataValid;
    daqWord_t    asicData;
    logic        resetB, startAcq, startReadout, onceEnd, allDone, transmitDone;
    logic        pwrOnA, pwrOnD, pwrOnDac;
    daqWord_t    outData;
    logic        outValid;
    logic        outReady = 1'b0;

    daqWord_t    expQ[$];  // Words the DUT should send
    daqWord_t    gotQ[$];  // Words taken at the output
    logic [31:0] lcgState = 32'h79eb;
    bit          randReady = 1'b0;
    int          cycles = 0;
    int          errors = 0;
    int          testsRun = 0;
    int          testsFailed = 0;
    int          trigTotal = 0;  // Triggers sent since run start
    cfgTime_t    acqSet;
    cfgTime_t    holdSet;

    daqTop dut0 (.*);

    always #20 Clk = ~Clk;

    always @(posedge Clk) cycles <= cycles + 1;

    initial begin
        wait (cycles >= TimeoutCycles);
        $display("Timeout: the tests did not finish within %0d cycles", TimeoutCycles);
        $display("*** TEST FAILED ***");
        $finish;
    end

    ////////////////////
    // Output sink

    function automatic logic [31:0] lcgNext(input logic [31:0] s);
        return s * 32'd1103515245 + 32'd12345;
    endfunction

    always @(posedge Clk) begin
        lcgState <= lcgNext(lcgState);
        outReady <= randReady ? lcgState[16] : 1'b1;
    end

    always @(negedge Clk)
        if (reset_n && outValid && outReady) gotQ.push_back(outData);  // Transfers next edge

    ////////////////////
    // Helpers

    task automatic checkEq(input string name, input logic [31:0] expected,
                           input logic [31:0] actual);
        if (expected !== actual) begin
            errors++;
            $display("Error in %s: expected %0h, actual %0h", name, expected, actual);
        end
    endtask

    task automatic endTest(input string name, input int errs0);
        testsRun++;
        if (errors > errs0) testsFailed++;
        $display("Test %s finished with %0d errors", name, errors - errs0);
    endtask

    task automatic axiWrite(input logic [3:0] addr, input logic [31:0] data);
        @(posedge Clk);
        awValid <= 1'b1;
        awAddr  <= addr;
        wValid  <= 1'b1;
        wData   <= data;
        wStrb   <= 4'hF;
        bReady  <= 1'b1;
        @(negedge Clk);
        while (!(awReady && wReady)) @(negedge Clk);
        @(posedge Clk);
        awValid <= 1'b0;
        wValid  <= 1'b0;
        @(negedge Clk);
        while (!bValid) @(negedge Clk);
        checkEq("write response", 32'd0, 32'(bResp));
        @(posedge Clk);
        bReady <= 1'b0;
    endtask

    task automatic axiRead(input logic [3:0] addr, output logic [31:0] data);
        @(posedge Clk);
        arValid <= 1'b1;
        arAddr  <= addr;
        rReady  <= 1'b1;
        @(negedge Clk);
        while (!arReady) @(negedge Clk);
        @(posedge Clk);
        arValid <= 1'b0;
        @(negedge Clk);
        while (!rValid) @(negedge Clk);
        data = rData;
        checkEq("read response", 32'd0, 32'(rResp));
        @(posedge Clk);
        rReady <= 1'b0;
    endtask

    task automatic waitState(input logic [3:0] target);
        logic [31:0] v;
        axiRead(`DAQ_ADDR_STATUS, v);
        while (v[3:0] != target) axiRead(`DAQ_ADDR_STATUS, v);
    endtask

    task automatic compareStream(input string name);
        daqWord_t expWord;
        daqWord_t gotWord;
        @(negedge Clk);
        while (gotQ.size() < expQ.size()) @(negedge Clk);
        while (expQ.size() > 0) begin
            expWord = expQ.pop_front();
            gotWord = gotQ.pop_front();
            checkEq(name, 32'(expWord), 32'(gotWord));
        end
        checkEq({name, " extra words"}, 32'd0, 32'(gotQ.size()));
    endtask

    // ASIC model for one trigger, window, readout and hold
    task automatic runCycle(input string name, input daqWord_t base, input int nWords,
                            input bit fullEarly, output int winLen);
        int holdLen;
        bit closed;
        waitState(WaitStart);
        @(posedge Clk);
        asicTrigger <= 1'b1;
        trigTotal++;
        repeat (2) @(posedge Clk);
        @(negedge Clk);
        checkEq({name, " startAcq early"}, 32'd0, 32'(startAcq));
        @(posedge Clk);
        asicTrigger <= 1'b0;
        @(negedge Clk);
        checkEq({name, " startAcq"}, 32'd1, 32'(startAcq));  // Three cycles after the edge
        winLen = 1;
        closed = 1'b0;
        while (!closed) begin
            @(posedge Clk);
            if (fullEarly && winLen == 4) asicChipSatB <= 1'b0;  // Chip full
            @(negedge Clk);
            if (startAcq) winLen++;
            else closed = 1'b1;
        end
        if (!fullEarly) begin
            @(posedge Clk);
            asicChipSatB <= 1'b0;
        end
        repeat (3) @(posedge Clk);
        asicChipSatB <= 1'b1;  // Saturation release
        @(negedge Clk);
        while (!startReadout) @(negedge Clk);
        for (int i = 0; i < nWords; i++) begin
            @(posedge Clk);
            asicDataValid <= 1'b1;
            asicData      <= base + daqWord_t'(i);
            expQ.push_back(base + daqWord_t'(i));
        end
        @(posedge Clk);
        asicDataValid <= 1'b0;
        @(posedge Clk);
        asicEndReadout <= 1'b1;
        @(posedge Clk);
        asicEndReadout <= 1'b0;
        @(negedge Clk);
        while (!onceEnd) @(negedge Clk);
        holdLen = 0;
        while (onceEnd) begin
            holdLen++;
            @(negedge Clk);
        end
        checkEq({name, " hold length"}, 32'(holdSet) + 1, 32'(holdLen));
    endtask

    ////////////////////
    // Tests

    task automatic registerAccess;
        int errs0;
        logic [31:0] v;
        errs0 = errors;
        @(negedge Clk);
        checkEq("reset controls", 32'b10000,
                32'({resetB, startAcq, startReadout, onceEnd, allDone}));
        checkEq("reset power", 32'd0, 32'({pwrOnA, pwrOnD, pwrOnDac}));
        checkEq("reset stream", 32'd0, 32'({outValid, transmitDone}));
        checkEq("reset AXI valid", 32'd0, 32'({bValid, rValid}));
        axiRead(`DAQ_ADDR_STATUS, v);
        checkEq("reset status", 32'd0, v);  // Idle, no overflow
        acqSet  = 16'd12;
        holdSet = 16'd5;
        axiWrite(`DAQ_ADDR_ACQ_TIME, 32'(acqSet));
        axiWrite(`DAQ_ADDR_HOLD_TIME, 32'(holdSet));
        axiRead(`DAQ_ADDR_ACQ_TIME, v);
        checkEq("acqTime readback", 32'(acqSet), v);
        axiRead(`DAQ_ADDR_HOLD_TIME, v);
        checkEq("holdTime readback", 32'(holdSet), v);
        endTest("register access", errs0);
    endtask

    task automatic timeWindow;
        int errs0;
        int win;
        errs0 = errors;
        axiWrite(`DAQ_ADDR_CTRL, 32'd1);
        @(negedge Clk);
        while (!pwrOnD) @(negedge Clk);
        checkEq("power on", 32'b111, 32'({pwrOnA, pwrOnD, pwrOnDac}));
        runCycle("time window", 16'h1100, 6, 1'b0, win);
        checkEq("time window length", 32'(acqSet) + 1, 32'(win));
        compareStream("time window data");
        endTest("window ended by time", errs0);
    endtask

    task automatic chipFullWindow;
        int errs0;
        int win;
        errs0 = errors;
        acqSet = 16'd200;
        axiWrite(`DAQ_ADDR_ACQ_TIME, 32'(acqSet));
        runCycle("chip full", 16'h2200, 5, 1'b1, win);
        checkEq("chip full window short", 32'd1, 32'(win < 32'(acqSet) + 1));
        compareStream("chip full data");
        acqSet = 16'd12;
        axiWrite(`DAQ_ADDR_ACQ_TIME, 32'(acqSet));
        endTest("window ended by chip full", errs0);
    endtask

    task automatic backPressure;
        int errs0;
        int win;
        logic [31:0] v;
        errs0 = errors;
        randReady <= 1'b1;
        runCycle("back-pressure", 16'h3300, `DAQ_FIFO_DEPTH, 1'b0, win);
        checkEq("back-pressure window length", 32'(acqSet) + 1, 32'(win));
        compareStream("back-pressure data");
        axiRead(`DAQ_ADDR_STATUS, v);
        checkEq("back-pressure overflow", 32'd0, 32'(v[4]));
        randReady <= 1'b0;
        endTest("back-pressure", errs0);
    endtask

    task automatic stopWithTrailer;
        int errs0;
        int win;
        int k;
        logic [31:0] v;
        errs0 = errors;
        runCycle("stop", 16'h4400, 3, 1'b0, win);
        checkEq("stop window length", 32'(acqSet) + 1, 32'(win));
        compareStream("stop data");
        k = trigTotal;
        axiWrite(`DAQ_ADDR_CTRL, 32'd0);
        expQ.push_back(16'hFF45);
        expQ.push_back({8'hCC, k[23:16]});
        expQ.push_back(k[15:0]);
        @(negedge Clk);
        while (!transmitDone) @(negedge Clk);
        checkEq("trailer sent before done", 32'(expQ.size()), 32'(gotQ.size()));
        compareStream("trailer");
        axiRead(`DAQ_ADDR_STATUS, v);
        checkEq("status after stop", 32'd0, 32'(v[5:0]));  // Idle, not done
        @(negedge Clk);
        checkEq("power after stop", 32'd0, 32'({pwrOnA, pwrOnD, pwrOnDac}));
        endTest("stop with trailer", errs0);
    endtask

    initial begin
        reset_n        = 1'b0;
        awValid        = 1'b0;
        awAddr         = 4'h0;
        wValid         = 1'b0;
        wData          = 32'd0;
        wStrb          = 4'h0;
        bReady         = 1'b0;
        arValid        = 1'b0;
        arAddr         = 4'h0;
        rReady         = 1'b0;
        asicTrigger    = 1'b0;
        asicChipSatB   = 1'b1;  // Rests high while no chip is full
        asicEndReadout = 1'b0;
        asicData       = '0;
        asicDataValid  = 1'b0;
        repeat (4) @(posedge Clk);
        reset_n <= 1'b1;
        registerAccess();
        timeWindow();
        chipFullWindow();
        backPressure();
        stopWithTrailer();
        $display("Tests run: %0d, tests failed: %0d, errors: %0d",
                 testsRun, testsFailed, errors);
        if (errors == 0)
            $display("*** TEST PASSED ***");
        else
            $display("*** TEST FAILED ***");
        $finish;
    end

endmodule

// File: all.f
+incdir+design
design/daqCtrlPkg.sv
design/daqDataPkg.sv
design/daqConfigRegs.sv
design/slaveDaq.sv
design/dataFifo.sv
design/streamOut.sv
design/daqTop.sv
test/tb_daqTop.sv

// File: run.sh
#!/bin/sh
# Build the DAQ controller testbench with Verilator, run it, and scan the log
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert -Wno-fatal -f all.f --top-module tb_daqTop \
    -o simDaq > build.log 2>&1 \
    && ./obj_dir/simDaq > sim.log 2>&1 \
    || { echo "Build or simulation did not complete, see build.log and sim.log"; exit 1; }
grep -qF "*** TEST PASSED ***" sim.log && echo "Simulation passed" \
    || { echo "Simulation failed, see sim.log"; exit 1; }
